//--- flist.f
source/video_pkg.sv
source/regs_pkg.sv
source/layer_ctrl_regs.sv
source/tile_shifter.sv
source/layer_priority_mixer.sv
source/scroll_layers_top.sv
tb/scroll_layers_tb.sv

//--- source/layer_ctrl_regs.sv
module layer_ctrl_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                reg_wr,
    input  regs_pkg::reg_write_t reg_wr_data,
    output regs_pkg::layer_ctrl_t ctrl
);

    localparam int NUM_REGS = 4;

    regs_pkg::reg_data_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (reg_wr) begin
            regs[reg_wr_data.addr] <= reg_wr_data.data;
        end
    end

    // Only the low bits of the scroll registers matter here
    always_comb begin
        ctrl.bg0_fine = regs[regs_pkg::REG_BG0_FINE][2:0];
        ctrl.bg1_fine = regs[regs_pkg::REG_BG1_FINE][2:0];
        ctrl.fg0_fine = regs[regs_pkg::REG_FG0_FINE][2:0];
        ctrl.bg0_en = regs[regs_pkg::REG_LAYER_CTRL][regs_pkg::CTRL_BG0_EN_BIT];
        ctrl.bg1_en = regs[regs_pkg::REG_LAYER_CTRL][regs_pkg::CTRL_BG1_EN_BIT];
        ctrl.fg0_en = regs[regs_pkg::REG_LAYER_CTRL][regs_pkg::CTRL_FG0_EN_BIT];
        ctrl.bg0_prio = regs[regs_pkg::REG_LAYER_CTRL][regs_pkg::CTRL_BG0_PRIO_BIT];
    end

    // CPU side must drive clean data with every write
    a_wr_data_known: assert property (
        @(posedge clk) disable iff (reset)
        reg_wr |-> !$isunknown(reg_wr_data)
    ) else $error("layer_ctrl_regs: unknown bits in reg_wr_data");

endmodule

//--- source/layer_priority_mixer.sv
module layer_priority_mixer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ce_pixel,
    input  regs_pkg::layer_ctrl_t ctrl,
    input  video_pkg::dot_t       bg0_dot,
    input  video_pkg::dot_t       bg1_dot,
    input  video_pkg::dot_t       fg0_dot,
    output video_pkg::color_t     color,
    output logic                  color_valid
);

    logic bg0_opaque;
    logic bg1_opaque;
    logic fg0_opaque;
    video_pkg::color_t sel_color;

    // Pen 0 in the low bits is see-through
    assign bg0_opaque = ctrl.bg0_en && (|bg0_dot[video_pkg::PIXEL_WIDTH-1:0]);
    assign bg1_opaque = ctrl.bg1_en && (|bg1_dot[video_pkg::PIXEL_WIDTH-1:0]);
    assign fg0_opaque = ctrl.fg0_en && (|fg0_dot[video_pkg::PIXEL_WIDTH-1:0]);

    always_comb begin
        sel_color = '0;
        if (fg0_opaque) begin
            sel_color = {video_pkg::LAYER_FG0, fg0_dot};
        end else if (bg0_opaque && (ctrl.bg0_prio || !bg1_opaque)) begin
            sel_color = {video_pkg::LAYER_BG0, bg0_dot};
        end else if (bg1_opaque) begin
            sel_color = {video_pkg::LAYER_BG1, bg1_dot};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            color <= '0;
            color_valid <= 1'b0;
        end else begin
            color_valid <= ce_pixel;
            if (ce_pixel) begin
                color <= sel_color;
            end
        end
    end

    // One output strobe per pixel enable, one clock later
    a_valid_follows_ce: assert property (
        @(posedge clk) disable iff (reset)
        ce_pixel |=> color_valid
    ) else $error("layer_priority_mixer: color_valid missing after ce_pixel");

    a_no_extra_valid: assert property (
        @(posedge clk) disable iff (reset)
        !ce_pixel |=> !color_valid
    ) else $error("layer_priority_mixer: color_valid without ce_pixel");

endmodule

//--- source/regs_pkg.sv
package regs_pkg;

    typedef logic [1:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    localparam reg_addr_t REG_BG0_FINE = 2'd0;
    localparam reg_addr_t REG_BG1_FINE = 2'd1;
    localparam reg_addr_t REG_FG0_FINE = 2'd2;
    localparam reg_addr_t REG_LAYER_CTRL = 2'd3;

    // Bit positions in the layer control register
    localparam int CTRL_BG0_EN_BIT = 0;
    localparam int CTRL_BG1_EN_BIT = 1;
    localparam int CTRL_FG0_EN_BIT = 2;
    localparam int CTRL_BG0_PRIO_BIT = 3;

    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } reg_write_t;

    // Dot offset within a tile column
    typedef logic [2:0] fine_scroll_t;

    typedef struct packed {
        fine_scroll_t bg0_fine;
        fine_scroll_t bg1_fine;
        fine_scroll_t fg0_fine;
        logic bg0_en;
        logic bg1_en;
        logic fg0_en;
        logic bg0_prio;
    } layer_ctrl_t;

endpackage

//--- source/scroll_layers_top.sv
module scroll_layers_top #(
    parameter int PALETTE_WIDTH = video_pkg::PALETTE_WIDTH,
    parameter int PIXEL_WIDTH = video_pkg::PIXEL_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ce_pixel,
    input  logic                   reg_wr,
    input  logic                   tile_load,
    input  regs_pkg::reg_write_t   reg_wr_data,
    input  video_pkg::tile_group_t tiles,
    output video_pkg::color_t      color,
    output logic                   color_valid
);

    regs_pkg::layer_ctrl_t ctrl;
    video_pkg::dot_t bg0_dot;
    video_pkg::dot_t bg1_dot;
    video_pkg::dot_t fg0_dot;

    layer_ctrl_regs ctrl_regs0 (
        .clk         (clk),
        .reset       (reset),
        .reg_wr      (reg_wr),
        .reg_wr_data (reg_wr_data),
        .ctrl        (ctrl)
    );

    // All three layers load on the same strobe
    tile_shifter #(
        .PALETTE_WIDTH (PALETTE_WIDTH),
        .PIXEL_WIDTH   (PIXEL_WIDTH)
    ) bg0_shift (
        .clk      (clk),
        .ce_pixel (ce_pixel),
        .load     (tile_load),
        .tile     (tiles.bg0),
        .fine     (ctrl.bg0_fine),
        .dot      (bg0_dot)
    );

    tile_shifter #(
        .PALETTE_WIDTH (PALETTE_WIDTH),
        .PIXEL_WIDTH   (PIXEL_WIDTH)
    ) bg1_shift (
        .clk      (clk),
        .ce_pixel (ce_pixel),
        .load     (tile_load),
        .tile     (tiles.bg1),
        .fine     (ctrl.bg1_fine),
        .dot      (bg1_dot)
    );

    tile_shifter #(
        .PALETTE_WIDTH (PALETTE_WIDTH),
        .PIXEL_WIDTH   (PIXEL_WIDTH)
    ) fg0_shift (
        .clk      (clk),
        .ce_pixel (ce_pixel),
        .load     (tile_load),
        .tile     (tiles.fg0),
        .fine     (ctrl.fg0_fine),
        .dot      (fg0_dot)
    );

    layer_priority_mixer mixer0 (
        .clk         (clk),
        .reset       (reset),
        .ce_pixel    (ce_pixel),
        .ctrl        (ctrl),
        .bg0_dot     (bg0_dot),
        .bg1_dot     (bg1_dot),
        .fg0_dot     (fg0_dot),
        .color       (color),
        .color_valid (color_valid)
    );

endmodule

//--- source/tile_shifter.sv
module tile_shifter #(
    parameter int PALETTE_WIDTH = 8,
    parameter int PIXEL_WIDTH = 4
) (
    input  logic                     clk,
    input  logic                     ce_pixel,
    input  logic                     load,
    input  video_pkg::tile_fetch_t   tile,
    input  regs_pkg::fine_scroll_t   fine,
    output video_pkg::dot_t          dot
);

    localparam int DOT_WIDTH = PALETTE_WIDTH + PIXEL_WIDTH;
    localparam int NUM_SLOTS = 16;
    localparam int TILE_PIXELS = 8;

    logic [NUM_SLOTS-1:0][DOT_WIDTH-1:0] slots;
    logic [3:0] tap;

    // Tap starts at slot 8, fine scroll moves it further up
    assign tap = 4'd8 + {1'b0, fine};
    assign dot = slots[tap];

    always_ff @(posedge clk) begin
        if (ce_pixel) begin
            for (int s = 1; s < NUM_SLOTS; s++) begin
                slots[s] <= slots[s-1];
            end
            if (load) begin
                // New row overrides the low half
                for (int i = 0; i < TILE_PIXELS; i++) begin
                    if (tile.flip_x) begin
                        slots[TILE_PIXELS-1-i] <=
                            {tile.palette, tile.gfx[PIXEL_WIDTH*i +: PIXEL_WIDTH]};
                    end else begin
                        slots[i] <= {tile.palette, tile.gfx[PIXEL_WIDTH*i +: PIXEL_WIDTH]};
                    end
                end
            end
        end
    end

    // Fetch side only loads on a pixel enable, else a row would be lost
    a_load_on_ce: assert property (
        @(posedge clk) load |-> ce_pixel
    ) else $error("tile_shifter: load without ce_pixel");

endmodule

//--- source/video_pkg.sv
package video_pkg;

    // Default widths of the dot fields
    localparam int PALETTE_WIDTH = 8;
    localparam int PIXEL_WIDTH = 4;

    localparam int DOT_WIDTH = PALETTE_WIDTH + PIXEL_WIDTH;
    localparam int TILE_PIXELS = 8;

    // Pen 0 is transparent
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [PALETTE_WIDTH-1:0] palette_t;

    // Palette bank above pen index
    typedef logic [DOT_WIDTH-1:0] dot_t;

    typedef logic [2:0] layer_code_t;

    // Layer tag above the dot
    typedef logic [$bits(layer_code_t)+DOT_WIDTH-1:0] color_t;

    localparam layer_code_t LAYER_BG0 = 3'd0;
    localparam layer_code_t LAYER_FG0 = 3'd2;
    localparam layer_code_t LAYER_BG1 = 3'd4;

    // One row of one tile column, pixel 0 in the low bits
    typedef struct packed {
        logic [TILE_PIXELS*PIXEL_WIDTH-1:0] gfx;
        palette_t palette;
        logic flip_x;
    } tile_fetch_t;

    typedef struct packed {
        tile_fetch_t bg0;
        tile_fetch_t bg1;
        tile_fetch_t fg0;
    } tile_group_t;

endpackage

//--- tb/scroll_layers_tb.sv
module scroll_layers_tb;

    localparam int PW = video_pkg::PIXEL_WIDTH;
    localparam int NUM_SLOTS = 16;

    logic clk = 1'b0;
    logic reset;
    logic ce_pixel;
    logic reg_wr;
    logic tile_load;
    regs_pkg::reg_write_t reg_wr_data;
    video_pkg::tile_group_t tiles;
    video_pkg::color_t color;
    logic color_valid;

    integer seed = 32'ha24d;
    int en_count = 0;
    int tile_count = 0;
    bit directed_fg0 = 1'b0;
    bit flip_sel = 1'b0;

    // Model of the three shifters and the decoded control
    video_pkg::dot_t mdl [3][NUM_SLOTS];
    regs_pkg::layer_ctrl_t mctrl;
    logic ce_seen;
    video_pkg::color_t exp_q [$];

    int check_count = 0;
    int mismatch_count = 0;
    int protocol_count = 0;
    int timeout_count = 0;

    scroll_layers_top #(
        .PALETTE_WIDTH (video_pkg::PALETTE_WIDTH),
        .PIXEL_WIDTH   (video_pkg::PIXEL_WIDTH)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .ce_pixel    (ce_pixel),
        .reg_wr      (reg_wr),
        .tile_load   (tile_load),
        .reg_wr_data (reg_wr_data),
        .tiles       (tiles),
        .color       (color),
        .color_valid (color_valid)
    );

    always #5 clk = ~clk;

    function automatic video_pkg::color_t ref_color(input video_pkg::dot_t b0,
                                                    input video_pkg::dot_t b1,
                                                    input video_pkg::dot_t f0,
                                                    input regs_pkg::layer_ctrl_t c);
        logic o0;
        logic o1;
        logic of;
        o0 = c.bg0_en && (b0[PW-1:0] != '0);
        o1 = c.bg1_en && (b1[PW-1:0] != '0);
        of = c.fg0_en && (f0[PW-1:0] != '0);
        if (of) return {video_pkg::LAYER_FG0, f0};
        if (o0 && o1) return c.bg0_prio ? {video_pkg::LAYER_BG0, b0} : {video_pkg::LAYER_BG1, b1};
        if (o0) return {video_pkg::LAYER_BG0, b0};
        if (o1) return {video_pkg::LAYER_BG1, b1};
        return '0;
    endfunction

    function automatic video_pkg::tile_fetch_t layer_tile(input int l);
        if (l == 0) return tiles.bg0;
        if (l == 1) return tiles.bg1;
        return tiles.fg0;
    endfunction

    task automatic advance_model();
        video_pkg::tile_fetch_t t;
        for (int l = 0; l < 3; l++) begin
            for (int s = NUM_SLOTS - 1; s > 0; s--) begin
                mdl[l][s] = mdl[l][s-1];
            end
            if (tile_load) begin
                t = layer_tile(l);
                for (int i = 0; i < 8; i++) begin
                    mdl[l][t.flip_x ? 7 - i : i] = {t.palette, t.gfx[PW*i +: PW]};
                end
            end
        end
    endtask

    task automatic apply_write(input regs_pkg::reg_write_t w);
        case (w.addr)
            regs_pkg::REG_BG0_FINE: mctrl.bg0_fine = w.data[2:0];
            regs_pkg::REG_BG1_FINE: mctrl.bg1_fine = w.data[2:0];
            regs_pkg::REG_FG0_FINE: mctrl.fg0_fine = w.data[2:0];
            default: begin
                mctrl.bg0_en = w.data[0];
                mctrl.bg1_en = w.data[1];
                mctrl.fg0_en = w.data[2];
                mctrl.bg0_prio = w.data[3];
            end
        endcase
    endtask

    // Expected color is taken from the slots as they stand before the shift
    always @(posedge clk) begin
        if (reset) begin
            mctrl = '0;
            ce_seen = 1'b0;
            for (int l = 0; l < 3; l++) begin
                for (int s = 0; s < NUM_SLOTS; s++) begin
                    mdl[l][s] = '0;
                end
            end
        end else begin
            ce_seen = ce_pixel;
            if (ce_pixel) begin
                exp_q.push_back(ref_color(mdl[0][8 + mctrl.bg0_fine],
                                          mdl[1][8 + mctrl.bg1_fine],
                                          mdl[2][8 + mctrl.fg0_fine], mctrl));
                advance_model();
            end
            if (reg_wr) begin
                apply_write(reg_wr_data);
            end
        end
    end

    always @(negedge clk) begin
        video_pkg::color_t exp;
        if (!reset) begin
            assert (color_valid === ce_seen) else begin
                protocol_count++;
                $display("MISMATCH time=%0t signal=color_valid expected=%b actual=%b",
                         $time, ce_seen, color_valid);
            end
            if (color_valid === 1'b1) begin
                assert (exp_q.size() > 0) else begin
                    protocol_count++;
                    $display("At %0t color_valid came with no pixel pending", $time);
                end
                if (exp_q.size() > 0) begin
                    exp = exp_q.pop_front();
                    check_count++;
                    assert (color === exp) else begin
                        mismatch_count++;
                        $display("MISMATCH time=%0t signal=color expected=%h actual=%h",
                                 $time, exp, color);
                    end
                end
            end
        end
    end

    task automatic random_fetch(output video_pkg::tile_fetch_t t);
        logic [31:0] r;
        r = $random(seed);
        t.gfx = r;
        r = $random(seed);
        t.palette = r[7:0];
        t.flip_x = r[8];
    endtask

    task automatic make_tiles();
        random_fetch(tiles.bg0);
        random_fetch(tiles.bg1);
        random_fetch(tiles.fg0);
        if (directed_fg0) begin
            // Two transparent pens in the row
            tiles.fg0.gfx = 32'h8706_5430;
            tiles.fg0.palette = 8'h40 + tile_count[7:0];
            tiles.fg0.flip_x = flip_sel;
        end
        tile_count++;
    endtask

    // ce_pixel on every second clock, a tile row on every 8th enable
    task automatic run_enables(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #1;
            reg_wr = 1'b0;
            ce_pixel = 1'b1;
            tile_load = (en_count % 8 == 0);
            if (tile_load) begin
                make_tiles();
            end
            en_count++;
            @(posedge clk);
            #1;
            ce_pixel = 1'b0;
            tile_load = 1'b0;
        end
    endtask

    task automatic write_reg(input regs_pkg::reg_addr_t addr, input logic [7:0] data);
        reg_wr_data.addr = addr;
        reg_wr_data.data = data;
        reg_wr = 1'b1;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        ce_pixel = 1'b0;
        reg_wr = 1'b0;
        tile_load = 1'b0;
        reg_wr_data = '0;
        tiles = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // All layers off while two rows fill every slot
        run_enables(24);

        directed_fg0 = 1'b1;
        write_reg(regs_pkg::REG_LAYER_CTRL, 8'h04);
        run_enables(32);
        flip_sel = 1'b1;
        run_enables(32);

        flip_sel = 1'b0;
        for (int f = 1; f < 8; f++) begin
            write_reg(regs_pkg::REG_FG0_FINE, f[7:0]);
            run_enables(16);
        end

        directed_fg0 = 1'b0;
        write_reg(regs_pkg::REG_LAYER_CTRL, 8'h07);
        run_enables(64);
        write_reg(regs_pkg::REG_BG0_FINE, 8'h03);
        write_reg(regs_pkg::REG_BG1_FINE, 8'h05);
        write_reg(regs_pkg::REG_LAYER_CTRL, 8'h0f);
        run_enables(64);

        // Dropping enables one at a time
        write_reg(regs_pkg::REG_LAYER_CTRL, 8'h0b);
        run_enables(32);
        write_reg(regs_pkg::REG_LAYER_CTRL, 8'h09);
        run_enables(32);
        write_reg(regs_pkg::REG_LAYER_CTRL, 8'h0a);
        run_enables(32);
        write_reg(regs_pkg::REG_LAYER_CTRL, 8'h08);
        run_enables(16);

        for (int w = 0; w < 20 && exp_q.size() != 0; w++) begin
            @(negedge clk);
        end
        assert (exp_q.size() == 0) else begin
            timeout_count++;
            $display("Timed out with %0d expected colors never output", exp_q.size());
        end

        $display("checks=%0d mismatches=%0d protocol errors=%0d timeouts=%0d",
                 check_count, mismatch_count, protocol_count, timeout_count);
        if (mismatch_count == 0 && protocol_count == 0 && timeout_count == 0
            && check_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
